// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - files:
      - verilog/l1_cache_pkg.sv
      - verilog/cache_array_if.sv
      - verilog/cache_store.sv
      - verilog/cache_ctrl.sv
      - verilog/l1_cache.sv
  - target: test
    files:
      - tests/l1_cache_asserts.sv
      - tests/l1_cache_mon.sv
      - tests/l1_cache_tb.sv

// ==== l1_cache.f ====
verilog/l1_cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_store.sv
verilog/cache_ctrl.sv
verilog/l1_cache.sv
tests/l1_cache_asserts.sv
tests/l1_cache_mon.sv
tests/l1_cache_tb.sv

// ==== tests/l1_cache_asserts.sv ====
// ------------------------------
// controller bus checks
// memory handshake and flush pulse
// ------------------------------

`timescale 1ns/1ps

module l1_cache_asserts (
    input logic                CLK,
    input logic                nRST,
    input logic                mem_ren,
    input logic                mem_wen,
    input l1_cache_pkg::word_t mem_addr,
    input l1_cache_pkg::word_t mem_wdata,
    input logic                mem_busy,
    input logic                flush_done
);
    int fails = 0;

    // request and fields held until memory accepts the word
    hold_request: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=>
            $stable({mem_ren, mem_wen, mem_addr}) && (!mem_wen || $stable(mem_wdata)))
        else begin
            $error("memory request changed while mem_busy was high");
            fails++;
        end

    one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            $error("mem_ren and mem_wen high together");
            fails++;
        end

    done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            $error("flush_done held longer than one cycle");
            fails++;
        end

endmodule

bind cache_ctrl l1_cache_asserts i_ctrl_asserts (.*);

// ==== tests/l1_cache_mon.sv ====
// ------------------------------
// L1 cache checker
// compares each finished access
// or flush with the data file
// ------------------------------

`timescale 1ns/1ps

module l1_cache_mon (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  logic                proc_busy,
    input  l1_cache_pkg::word_t proc_rdata,
    input  logic                mem_wen,
    input  logic                mem_busy,
    input  logic                flush_done,
    input  logic [1:0]          cur_op,     // 0 read, 1 write, 2 flush, 3 none
    input  l1_cache_pkg::word_t exp_rdata,
    input  int                  exp_writes,
    input  int                  line_no,
    output int                  test_count,
    output int                  error_count
);
    int   writes = 0; // memory writes since the last finished test
    logic done;
    logic ok;

    initial begin
        test_count  = 0;
        error_count = 0;
    end

    function automatic string op_name(logic [1:0] op);
        case (op)
            2'd0:    return "read";
            2'd1:    return "write";
            default: return "flush";
        endcase
    endfunction

    always @(posedge CLK) begin
        if (nRST) begin
            if (mem_wen && !mem_busy) writes = writes + 1;
            if (flush_done && cur_op != 2'd2) begin
                $display("flush_done pulsed at %0t with no flush requested", $time);
                error_count = error_count + 1;
            end
            done = (cur_op == 2'd2) ? flush_done
                 : (cur_op < 2'd2) && (proc_ren || proc_wen) && !proc_busy;
            if (done) begin
                ok = 1'b1;
                if (cur_op == 2'd0 && proc_rdata !== exp_rdata) begin
                    $display("[ERROR] %0t proc_rdata expected %h got %h",
                             $time, exp_rdata, proc_rdata);
                    ok = 1'b0;
                    error_count = error_count + 1;
                end
                if (writes != exp_writes) begin
                    $display("[ERROR] %0t mem_wen count expected %0d got %0d",
                             $time, exp_writes, writes);
                    ok = 1'b0;
                    error_count = error_count + 1;
                end
                test_count = test_count + 1;
                $display("test %0d %s: %s", line_no, op_name(cur_op), ok ? "ok" : "FAILED");
                writes = 0;
            end
        end
    end

endmodule

// ==== tests/l1_cache_tb.sv ====
// ------------------------------
// L1 cache testbench
// clock, reset, memory model and
// stimulus from the data file
// ------------------------------

`timescale 1ns/1ps

module l1_cache_tb;
    localparam int MAX_LINES = 64;
    localparam int COLS      = 6; // op, addr, byte_en, wdata, rdata, mem writes

    logic                   CLK = 1'b0;
    logic                   nRST;
    logic                   flush, flush_done;
    logic                   proc_ren, proc_wen, proc_busy;
    l1_cache_pkg::word_t    proc_addr, proc_wdata, proc_rdata;
    l1_cache_pkg::byte_en_t proc_byte_en;
    logic                   mem_ren, mem_wen, mem_busy;
    l1_cache_pkg::word_t    mem_addr, mem_wdata, mem_rdata;

    logic [1:0]          cur_op;
    l1_cache_pkg::word_t exp_rdata;
    int                  exp_writes, line_no;
    int                  test_count, error_count, total_errors;

    l1_cache_pkg::word_t vectors   [MAX_LINES*COLS];
    l1_cache_pkg::word_t mem_words [256]; // bit 31 and word index 6..0 of the address
    int                  n_lines, cycles, cycle_limit, wait_left;
    integer              seed;

    always #50 CLK = ~CLK;

    l1_cache #(
        .CACHE_SIZE          (64),
        .BLOCK_SIZE          (2),
        .ASSOC               (2),
        .NONCACHE_START_ADDR (32'h8000_0000)
    ) i_l1_cache (.*);

    l1_cache_mon i_l1_cache_mon (.*);

    function automatic int mem_index(l1_cache_pkg::word_t addr);
        return {addr[31], addr[8:2]};
    endfunction

    // word address xor constant for the byte address the slot stands for
    function automatic l1_cache_pkg::word_t init_word(int idx);
        l1_cache_pkg::word_t byte_addr;
        byte_addr = {idx[7], 22'b0, idx[6:0], 2'b00};
        return (byte_addr >> 2) ^ 32'hA5A5_0000;
    endfunction

    // memory with 0 to 2 busy cycles per word
    assign mem_busy  = (wait_left != 0);

    // read data only while a read is requested
    assign mem_rdata = mem_ren ? mem_words[mem_index(mem_addr)] : 'x;

    always @(posedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                if (mem_wen) mem_words[mem_index(mem_addr)] <= mem_wdata;
                wait_left <= $unsigned($random(seed)) % 3;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: test %0d did not finish within %0d cycles", line_no, cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // present one line and wait for its access or flush to finish
    task automatic run_line(int n);
        l1_cache_pkg::word_t op;
        op           = vectors[n*COLS];
        line_no      = n + 1;
        cur_op       = op[1:0];
        proc_addr    = vectors[n*COLS+1];
        proc_byte_en = vectors[n*COLS+2][3:0];
        proc_wdata   = vectors[n*COLS+3];
        exp_rdata    = vectors[n*COLS+4];
        exp_writes   = vectors[n*COLS+5];
        proc_ren     = (op == 0);
        proc_wen     = (op == 1);
        flush        = (op == 2);
        if (op == 2) begin
            do begin
                @(posedge CLK);
            end while (!flush_done);
        end else begin
            do begin
                @(posedge CLK);
            end while (proc_busy);
        end
        @(negedge CLK);
    endtask

    initial begin
        seed         = 16625;
        wait_left    = 0;
        cycles       = 0;
        cycle_limit  = 0;
        nRST         = 1'b0;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        cur_op       = 2'd3;
        exp_rdata    = '0;
        exp_writes   = 0;
        line_no      = 0;
        for (int i = 0; i < 256; i++) mem_words[i] = init_word(i);
        for (int i = 0; i < MAX_LINES*COLS; i++) vectors[i] = '1; // all ones marks the end
        $readmemh("tests/l1_cache_testdata.txt", vectors);
        n_lines = 0;
        while (n_lines < MAX_LINES && vectors[n_lines*COLS] != '1) n_lines++;
        cycle_limit = 40 * n_lines + 200;

        repeat (5) @(negedge CLK);
        nRST = 1'b1;
        for (int n = 0; n < n_lines; n++) run_line(n);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        flush    = 1'b0;
        cur_op   = 2'd3;
        repeat (2) @(negedge CLK);

        total_errors = error_count + i_l1_cache.i_cache_ctrl.i_ctrl_asserts.fails;
        $display("tests: %0d, errors: %0d", test_count, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tests/l1_cache_testdata.txt ====
// op (0 read, 1 write, 2 flush)  addr  byte_en  wdata  expected rdata  memory writes
// all hex, expected rdata is checked on reads only
0 00000000 f 00000000 a5a50000 0
0 00000004 f 00000000 a5a50001 0
1 00000004 3 11223344 00000000 0
0 00000004 f 00000000 a5a53344 0
1 00000000 0 deadbeef 00000000 0
0 00000000 f 00000000 deadbeef 0
0 00000020 f 00000000 a5a50008 0
0 00000040 f 00000000 a5a50010 2
0 00000000 f 00000000 deadbeef 0
0 00000004 f 00000000 a5a53344 0
0 80000020 6 00000000 00a50000 0
1 80000010 3 12345678 00000000 1
0 80000010 f 00000000 00005678 0
1 00000008 c cafe0000 00000000 0
1 00000000 1 00000011 00000000 0
2 00000000 0 00000000 00000000 4
2 00000000 0 00000000 00000000 0
0 00000020 f 00000000 a5a50008 0
0 00000060 f 00000000 a5a50018 0
0 00000000 f 00000000 deadbe11 0
0 00000004 f 00000000 a5a53344 0

// ==== verilog/cache_array_if.sv ====
// ------------------------------
// cache storage port
// lookup, victim info and write
// commands between ctrl and store
// ------------------------------

`timescale 1ns/1ps

interface cache_array_if #(
    parameter int CACHE_SIZE = 1024, // bytes
    parameter int BLOCK_SIZE = 2,    // words per block
    parameter int ASSOC      = 1     // 1 or 2 ways
);
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * l1_cache_pkg::BYTES_PER_WORD) / ASSOC;
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS   = l1_cache_pkg::WORD_SIZE - SET_BITS - BLOCK_BITS
                                - l1_cache_pkg::BYTE_OFFSET_BITS;

    // lookup and frame select
    logic [SET_BITS-1:0]   set;
    logic [TAG_BITS-1:0]   tag;
    logic                  way;  // frame used for read, write and victim info
    logic [BLOCK_BITS-1:0] widx; // word within the block

    // from the store
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [TAG_BITS-1:0]   victim_tag;
    l1_cache_pkg::word_t   rdata;

    // commands, at most one per cycle
    logic                   wen;
    logic                   wdirty; // processor write, marks the frame dirty
    l1_cache_pkg::word_t    wdata;
    l1_cache_pkg::byte_en_t wbe;
    logic                   fill;   // block complete, set valid and tag
    logic                   clean;
    logic                   touch;

    modport ctrl (
        output set, tag, way, widx, wen, wdirty, wdata, wbe, fill, clean, touch,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, rdata
    );

    modport store (
        input  set, tag, way, widx, wen, wdirty, wdata, wbe, fill, clean, touch,
        output hit, hit_way, victim_way, victim_dirty, victim_tag, rdata
    );

endinterface

// ==== verilog/cache_ctrl.sv ====
// ------------------------------
// L1 cache controller
// hit/miss FSM, block fetch and
// write-back, pass-through, flush
// ------------------------------

`timescale 1ns/1ps

module cache_ctrl #(
    parameter int                  CACHE_SIZE          = 1024,
    parameter int                  BLOCK_SIZE          = 2,
    parameter int                  ASSOC               = 1,
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   flush,
    output logic                   flush_done,
    input  logic                   proc_ren,
    input  logic                   proc_wen,
    input  l1_cache_pkg::word_t    proc_addr,
    input  l1_cache_pkg::word_t    proc_wdata,
    input  l1_cache_pkg::byte_en_t proc_byte_en,
    output l1_cache_pkg::word_t    proc_rdata,
    output logic                   proc_busy,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output l1_cache_pkg::word_t    mem_addr,
    output l1_cache_pkg::word_t    mem_wdata,
    input  l1_cache_pkg::word_t    mem_rdata,
    input  logic                   mem_busy,
    cache_array_if.ctrl            array
);
    localparam int N_SETS      = CACHE_SIZE / (BLOCK_SIZE * l1_cache_pkg::BYTES_PER_WORD) / ASSOC;
    localparam int SET_BITS    = $clog2(N_SETS);
    localparam int BLOCK_BITS  = $clog2(BLOCK_SIZE);
    localparam int OFFSET_BITS = BLOCK_BITS + l1_cache_pkg::BYTE_OFFSET_BITS;
    localparam int TAG_BITS    = l1_cache_pkg::WORD_SIZE - SET_BITS - OFFSET_BITS;

    l1_cache_pkg::cache_state_t state, next_state;

    logic [BLOCK_BITS:0]       word_cnt, next_word_cnt; // counts up to BLOCK_SIZE
    logic [TAG_BITS+SET_BITS-1:0] blk_addr, next_blk_addr; // tag and set of the block on the bus
    logic [SET_BITS-1:0]       set_cnt, next_set_cnt;
    logic                      way_cnt, next_way_cnt;

    logic [TAG_BITS-1:0]   addr_tag;
    logic [SET_BITS-1:0]   addr_set;
    logic [BLOCK_BITS-1:0] addr_word;
    logic                  req, pass, finish_word, last_frame;
    logic [SET_BITS-1:0]   step_set;
    logic                  step_way;
    l1_cache_pkg::word_t   lane_mask;

    // processor address fields
    assign addr_tag  = proc_addr[l1_cache_pkg::WORD_SIZE-1 -: TAG_BITS];
    assign addr_set  = proc_addr[OFFSET_BITS +: SET_BITS];
    assign addr_word = proc_addr[l1_cache_pkg::BYTE_OFFSET_BITS +: BLOCK_BITS];

    assign req         = proc_ren || proc_wen;
    assign pass        = (proc_addr >= NONCACHE_START_ADDR);
    assign finish_word = (word_cnt == (BLOCK_BITS+1)'(BLOCK_SIZE));

    // sweep order is way first, then set
    assign step_way   = (ASSOC > 1) ? ~way_cnt : 1'b0;
    assign step_set   = (way_cnt == 1'(ASSOC - 1)) ? set_cnt + 1'b1 : set_cnt;
    assign last_frame = (set_cnt == SET_BITS'(N_SETS - 1)) && (way_cnt == 1'(ASSOC - 1));

    // pass-through lanes, no bits set means whole word
    always_comb begin
        lane_mask = '0;
        for (int b = 0; b < l1_cache_pkg::BYTES_PER_WORD; b++) begin
            if (proc_byte_en[b] || (proc_byte_en == '0)) begin
                lane_mask[8*b +: 8] = 8'hff;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= l1_cache_pkg::IDLE;
            word_cnt <= '0;
            set_cnt  <= '0;
            way_cnt  <= 1'b0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            set_cnt  <= next_set_cnt;
            way_cnt  <= next_way_cnt;
        end
    end

    always_ff @(posedge CLK) begin
        blk_addr <= next_blk_addr;
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_blk_addr = blk_addr;
        next_set_cnt  = set_cnt;
        next_way_cnt  = way_cnt;

        proc_busy  = 1'b1;
        proc_rdata = array.rdata;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = {blk_addr, word_cnt[BLOCK_BITS-1:0], {l1_cache_pkg::BYTE_OFFSET_BITS{1'b0}}};
        mem_wdata  = array.rdata; // write-back word
        flush_done = 1'b0;

        array.set    = addr_set;
        array.tag    = addr_tag;
        array.way    = array.victim_way;
        array.widx   = word_cnt[BLOCK_BITS-1:0];
        array.wen    = 1'b0;
        array.wdirty = 1'b0;
        array.wdata  = mem_rdata; // fill data
        array.wbe    = '1;
        array.fill   = 1'b0;
        array.clean  = 1'b0;
        array.touch  = 1'b0;

        case (state)
            l1_cache_pkg::IDLE: begin
                array.widx = addr_word;
                proc_busy  = req;
                if (req && pass) begin
                    mem_ren    = proc_ren;
                    mem_wen    = proc_wen && !proc_ren; // read wins
                    mem_addr   = proc_addr;
                    mem_wdata  = proc_wdata & lane_mask;
                    proc_rdata = mem_rdata & lane_mask;
                    proc_busy  = mem_busy;
                end else if (req && array.hit) begin
                    array.way   = array.hit_way;
                    array.touch = 1'b1;
                    proc_busy   = 1'b0;
                    if (!proc_ren) begin
                        array.wen    = 1'b1;
                        array.wdirty = 1'b1;
                        array.wdata  = proc_wdata;
                        array.wbe    = proc_byte_en;
                    end
                end else if (req) begin
                    // miss, victim first if dirty
                    if (array.victim_dirty) begin
                        next_blk_addr = {array.victim_tag, addr_set};
                        next_state    = l1_cache_pkg::WB;
                    end else begin
                        next_blk_addr = {addr_tag, addr_set};
                        next_state    = l1_cache_pkg::FETCH;
                    end
                end else if (flush) begin
                    next_state = l1_cache_pkg::FLUSH_SCAN;
                end
            end
            l1_cache_pkg::FETCH: begin
                if (finish_word) begin
                    array.fill    = 1'b1;
                    next_word_cnt = '0;
                    next_state    = l1_cache_pkg::IDLE; // access retires there as a hit
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        array.wen     = 1'b1;
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            l1_cache_pkg::WB: begin
                if (finish_word) begin
                    array.clean   = 1'b1;
                    next_word_cnt = '0;
                    next_blk_addr = {addr_tag, addr_set};
                    next_state    = l1_cache_pkg::FETCH;
                end else begin
                    mem_wen = 1'b1;
                    if (!mem_busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            l1_cache_pkg::FLUSH_SCAN: begin
                array.set = set_cnt;
                array.way = way_cnt;
                if (array.victim_dirty) begin
                    next_blk_addr = {array.victim_tag, set_cnt};
                    next_state    = l1_cache_pkg::FLUSH_FRAME;
                end else begin
                    next_set_cnt = step_set;
                    next_way_cnt = step_way;
                    if (last_frame) begin
                        flush_done = 1'b1;
                        next_state = l1_cache_pkg::IDLE;
                    end
                end
            end
            l1_cache_pkg::FLUSH_FRAME: begin
                array.set = set_cnt;
                array.way = way_cnt;
                if (finish_word) begin
                    array.clean   = 1'b1;
                    next_word_cnt = '0;
                    next_set_cnt  = step_set;
                    next_way_cnt  = step_way;
                    if (last_frame) begin
                        flush_done = 1'b1;
                        next_state = l1_cache_pkg::IDLE;
                    end else begin
                        next_state = l1_cache_pkg::FLUSH_SCAN;
                    end
                end else begin
                    mem_wen = 1'b1;
                    if (!mem_busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            default: next_state = l1_cache_pkg::IDLE;
        endcase
    end

endmodule

// ==== verilog/cache_store.sv ====
// ------------------------------
// cache storage
// tag/data/valid/dirty frames,
// tag compare and 1-bit LRU
// ------------------------------

`timescale 1ns/1ps

module cache_store #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 1
) (
    input logic CLK,
    input logic nRST,
    cache_array_if.store array
);
    localparam int N_FRAMES   = CACHE_SIZE / (BLOCK_SIZE * l1_cache_pkg::BYTES_PER_WORD);
    localparam int N_SETS     = N_FRAMES / ASSOC;
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS   = l1_cache_pkg::WORD_SIZE - SET_BITS - BLOCK_BITS
                                - l1_cache_pkg::BYTE_OFFSET_BITS;

    // frame contents
    logic                valid     [N_SETS][ASSOC];
    logic                dirty     [N_SETS][ASSOC];
    logic [TAG_BITS-1:0] tags      [N_SETS][ASSOC];
    l1_cache_pkg::word_t data      [N_SETS][ASSOC][BLOCK_SIZE];
    logic                last_used [N_SETS]; // way touched most recently

    l1_cache_pkg::byte_en_t lanes;

    // tag compare over the addressed set
    always_comb begin
        array.hit     = 1'b0;
        array.hit_way = 1'b0;
        for (int w = 0; w < ASSOC; w++) begin
            if (valid[array.set][w] && (tags[array.set][w] == array.tag)) begin
                array.hit     = 1'b1;
                array.hit_way = 1'(w);
            end
        end
    end

    // direct-mapped always replaces way 0
    assign array.victim_way = (ASSOC > 1) ? ~last_used[array.set] : 1'b0;

    // frame selected by the controller
    assign array.victim_dirty = dirty[array.set][array.way];
    assign array.victim_tag   = tags[array.set][array.way];
    assign array.rdata        = data[array.set][array.way][array.widx];

    // empty mask means whole word
    assign lanes = (array.wbe == '0) ? '1 : array.wbe;

    always_ff @(posedge CLK) begin
        if (array.wen) begin
            for (int b = 0; b < l1_cache_pkg::BYTES_PER_WORD; b++) begin
                if (lanes[b]) begin
                    data[array.set][array.way][array.widx][8*b +: 8] <= array.wdata[8*b +: 8];
                end
            end
        end
        if (array.fill) begin
            tags[array.set][array.way] <= array.tag;
        end
    end

    // frame state bits and replacement
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                for (int w = 0; w < ASSOC; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
                last_used[s] <= 1'b0;
            end
        end else begin
            if (array.wen && array.wdirty) begin
                dirty[array.set][array.way] <= 1'b1;
            end
            if (array.fill) begin
                valid[array.set][array.way] <= 1'b1;
                dirty[array.set][array.way] <= 1'b0; // freshly fetched block
            end
            if (array.clean) begin
                dirty[array.set][array.way] <= 1'b0;
            end
            if (array.touch) begin
                last_used[array.set] <= array.way;
            end
        end
    end

endmodule

// ==== verilog/l1_cache.sv ====
// ------------------------------
// L1 cache top level
// processor and memory bus ports,
// controller plus frame storage
// ------------------------------

`timescale 1ns/1ps

module l1_cache #(
    parameter int                  CACHE_SIZE          = 1024, // bytes, power of 2
    parameter int                  BLOCK_SIZE          = 2,    // words, 2 to 8
    parameter int                  ASSOC               = 1,    // 1 or 2
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   flush,
    output logic                   flush_done,
    // processor side
    input  logic                   proc_ren,
    input  logic                   proc_wen,
    input  l1_cache_pkg::word_t    proc_addr,
    input  l1_cache_pkg::word_t    proc_wdata,
    input  l1_cache_pkg::byte_en_t proc_byte_en,
    output l1_cache_pkg::word_t    proc_rdata,
    output logic                   proc_busy,
    // memory side
    output logic                   mem_ren,
    output logic                   mem_wen,
    output l1_cache_pkg::word_t    mem_addr,
    output l1_cache_pkg::word_t    mem_wdata,
    input  l1_cache_pkg::word_t    mem_rdata,
    input  logic                   mem_busy
);

    cache_array_if #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE),
        .ASSOC      (ASSOC)
    ) cache_array ();

    cache_store #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE),
        .ASSOC      (ASSOC)
    ) i_cache_store (
        .CLK   (CLK),
        .nRST  (nRST),
        .array (cache_array.store)
    );

    cache_ctrl #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .ASSOC               (ASSOC),
        .NONCACHE_START_ADDR (NONCACHE_START_ADDR)
    ) i_cache_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .array        (cache_array.ctrl)
    );

endmodule

// ==== verilog/l1_cache_pkg.sv ====
// ------------------------------
// L1 cache shared definitions
// bus word, lane mask and the
// controller state encoding
// ------------------------------

package l1_cache_pkg;

    // both buses carry 32-bit words and addresses
    localparam int WORD_SIZE = 32;

    localparam int BYTES_PER_WORD = WORD_SIZE / 8; // one byte lane per bit of byte_en_t

    // address bits below the word index
    localparam int BYTE_OFFSET_BITS = 2;

    // one bus word
    typedef logic [WORD_SIZE-1:0] word_t;

    // lane mask, bit n selects bits 8n+7..8n
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // controller states
    //   IDLE         hits, pass-through and request decode
    //   FETCH        block fill from memory, one extra cycle to mark the frame valid
    //   WB           dirty victim write-back before the fill
    //   FLUSH_SCAN   one cycle per frame of the sweep
    //   FLUSH_FRAME  write-back of one dirty frame during flush
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WB,
        FLUSH_SCAN,
        FLUSH_FRAME
    } cache_state_t;

endpackage
